//--- logic/im2col_pkg.sv
// ========================================================================
// im2col SPC package
// DMA register map, field masks, write sequence and the packed
// transaction, configuration and bus request types
// ========================================================================

package im2col_pkg;

  localparam int unsigned DMA_CH_NUM = 4;
  localparam int unsigned CH_IDX_W   = 2;
  localparam int unsigned FIFO_DEPTH = 4;

  localparam logic [31:0] DMA_START_ADDRESS = 32'h5000_0000;
  localparam logic [31:0] DMA_CH_SIZE       = 32'h0000_0100;  // Stride between channels

  localparam logic [31:0] DMA_SRC_PTR_OFFSET        = 32'h00;
  localparam logic [31:0] DMA_DST_PTR_OFFSET        = 32'h04;
  localparam logic [31:0] DMA_SIZE_D1_OFFSET        = 32'h0C;
  localparam logic [31:0] DMA_SIZE_D2_OFFSET        = 32'h10;
  localparam logic [31:0] DMA_INC_SRC_D1_OFFSET     = 32'h18;
  localparam logic [31:0] DMA_INC_SRC_D2_OFFSET     = 32'h1C;
  localparam logic [31:0] DMA_INC_DST_D1_OFFSET     = 32'h20;
  localparam logic [31:0] DMA_INC_DST_D2_OFFSET     = 32'h24;
  localparam logic [31:0] DMA_SRC_DATATYPE_OFFSET   = 32'h2C;
  localparam logic [31:0] DMA_DST_DATATYPE_OFFSET   = 32'h30;
  localparam logic [31:0] DMA_DIMENSIONALITY_OFFSET = 32'h3C;
  localparam logic [31:0] DMA_TOP_PAD_OFFSET        = 32'h44;
  localparam logic [31:0] DMA_BOTTOM_PAD_OFFSET     = 32'h48;
  localparam logic [31:0] DMA_RIGHT_PAD_OFFSET      = 32'h4C;
  localparam logic [31:0] DMA_LEFT_PAD_OFFSET       = 32'h50;

  localparam logic [31:0] MASK_DTYPE  = 32'h0000_0003;  // 2 bits
  localparam logic [31:0] MASK_PAD    = 32'h0000_003F;  // 6 bits, also D1 increments
  localparam logic [31:0] MASK_INC_D2 = 32'h007F_FFFF;  // 23 bits
  localparam logic [31:0] MASK_SIZE   = 32'h0000_FFFF;  // 16 bits

  // Channel programming order, the first three only on a channel's first use
  typedef enum logic [3:0] {
    STEP_DIM,
    STEP_SRC_DTYPE,
    STEP_DST_DTYPE,
    STEP_TOP_PAD,
    STEP_BOTTOM_PAD,
    STEP_LEFT_PAD,
    STEP_RIGHT_PAD,
    STEP_SRC_PTR,
    STEP_DST_PTR,
    STEP_INC_SRC_D1,
    STEP_INC_SRC_D2,
    STEP_INC_DST_D1,
    STEP_INC_DST_D2,
    STEP_SIZE_D2,
    STEP_SIZE_D1
  } reg_step_e;

  typedef struct packed {
    logic [31:0] input_ptr;
    logic [31:0] output_ptr;
    logic [3:0]  n_zeros_top;
    logic [3:0]  n_zeros_bottom;
    logic [3:0]  n_zeros_left;
    logic [3:0]  n_zeros_right;
    logic [15:0] in_inc_d2;
    logic [15:0] size_du_d1;
    logic [15:0] size_du_d2;
  } im2col_trans_t;

  typedef struct packed {
    logic [1:0]            data_type;  // Bytes per element = 4 >> data_type
    logic [7:0]            strides_d1;
    logic [DMA_CH_NUM-1:0] ch_mask;
    logic                  interrupt_en;
  } im2col_cfg_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

endpackage

//--- logic/trans_fifo.sv
// ========================================================================
// Transaction queue
// Circular buffer with first-word fall-through, payload set by type
// ========================================================================

`timescale 1ns/1ps

module trans_fifo #(
  parameter type         dtype = logic [31:0],
  parameter int unsigned DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  dtype data_i,
  input  logic pop_i,
  output dtype data_o,
  output logic empty_o,
  output logic full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  dtype             mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && !full_o;  // Push while full is dropped
  assign do_pop  = pop_i && !empty_o;
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign data_o  = mem_q[rd_ptr_q];  // Head visible without a pop

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

//--- logic/dma_channel_alloc.sv
// ========================================================================
// DMA channel allocator
// Busy and used flags per channel and the lowest free enabled channel pick
// ========================================================================

`timescale 1ns/1ps

module dma_channel_alloc (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [im2col_pkg::DMA_CH_NUM-1:0]   ch_mask_i,
  input  logic [im2col_pkg::DMA_CH_NUM-1:0]   dma_done_i,
  input  logic                                claim_i,
  input  logic                                run_end_i,
  output logic [im2col_pkg::CH_IDX_W-1:0]     ch_o,
  output logic                                first_use_o,
  output logic                                full_o,
  output logic                                idle_o
);

  logic [im2col_pkg::DMA_CH_NUM-1:0] busy_q;
  logic [im2col_pkg::DMA_CH_NUM-1:0] used_q;  // Set once programmed in this run
  logic [im2col_pkg::CH_IDX_W-1:0]   free_ch;
  logic                              found;

  // Lowest index wins
  always_comb begin
    free_ch = '0;
    found   = 1'b0;
    for (int i = 0; i < im2col_pkg::DMA_CH_NUM; i++) begin
      if (!found && !busy_q[i] && ch_mask_i[i]) begin
        free_ch = im2col_pkg::CH_IDX_W'(i);
        found   = 1'b1;
      end
    end
  end

  assign full_o = !found;
  assign idle_o = ~|busy_q;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= '0;
      used_q      <= '0;
      ch_o        <= '0;
      first_use_o <= 1'b0;
    end else begin
      busy_q <= busy_q & ~dma_done_i;  // Done frees the channel
      if (run_end_i) begin
        used_q <= '0;
      end
      if (claim_i) begin
        ch_o            <= free_ch;
        first_use_o     <= used_q[free_ch];  // Previous value is low on first use
        busy_q[free_ch] <= 1'b1;
        used_q[free_ch] <= 1'b1;
      end
    end
  end

  // Dispatch must only claim while an enabled channel is free
  a_claim_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    claim_i |-> found);

endmodule

//--- logic/dma_reg_writer.sv
// ========================================================================
// DMA register writer
// Walks the channel register sequence and issues scaled, masked writes
// on the request bus, one idle cycle between accepted writes
// ========================================================================

`timescale 1ns/1ps

module dma_reg_writer (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            start_i,
  input  logic [im2col_pkg::CH_IDX_W-1:0] ch_i,
  input  logic                            first_use_i,
  input  im2col_pkg::im2col_trans_t       trans_i,
  input  im2col_pkg::im2col_cfg_t         cfg_i,
  input  logic                            bus_ready_i,
  output im2col_pkg::bus_req_t            bus_req_o,
  output logic                            loaded_o
);

  typedef enum logic [1:0] {
    W_IDLE,
    W_SETUP,  // Channel and first-use bit settle here
    W_REQ,
    W_GAP
  } wr_state_e;

  wr_state_e             state_q;
  im2col_pkg::reg_step_e step_q;
  logic                  loaded_q;
  logic [31:0]           bpe;
  logic [31:0]           offset;
  logic [31:0]           wdata;

  assign bpe = 32'd4 >> cfg_i.data_type;  // Bytes per element

  always_comb begin
    offset = '0;
    wdata  = '0;
    unique case (step_q)
      im2col_pkg::STEP_DIM: begin
        offset = im2col_pkg::DMA_DIMENSIONALITY_OFFSET;
        wdata  = 32'd1;  // Always 2D
      end
      im2col_pkg::STEP_SRC_DTYPE: begin
        offset = im2col_pkg::DMA_SRC_DATATYPE_OFFSET;
        wdata  = 32'(cfg_i.data_type) & im2col_pkg::MASK_DTYPE;
      end
      im2col_pkg::STEP_DST_DTYPE: begin
        offset = im2col_pkg::DMA_DST_DATATYPE_OFFSET;
        wdata  = 32'(cfg_i.data_type) & im2col_pkg::MASK_DTYPE;
      end
      im2col_pkg::STEP_TOP_PAD: begin
        offset = im2col_pkg::DMA_TOP_PAD_OFFSET;
        wdata  = (32'(trans_i.n_zeros_top) * bpe) & im2col_pkg::MASK_PAD;
      end
      im2col_pkg::STEP_BOTTOM_PAD: begin
        offset = im2col_pkg::DMA_BOTTOM_PAD_OFFSET;
        wdata  = (32'(trans_i.n_zeros_bottom) * bpe) & im2col_pkg::MASK_PAD;
      end
      im2col_pkg::STEP_LEFT_PAD: begin
        offset = im2col_pkg::DMA_LEFT_PAD_OFFSET;
        wdata  = (32'(trans_i.n_zeros_left) * bpe) & im2col_pkg::MASK_PAD;
      end
      im2col_pkg::STEP_RIGHT_PAD: begin
        offset = im2col_pkg::DMA_RIGHT_PAD_OFFSET;
        wdata  = (32'(trans_i.n_zeros_right) * bpe) & im2col_pkg::MASK_PAD;
      end
      im2col_pkg::STEP_SRC_PTR: begin
        offset = im2col_pkg::DMA_SRC_PTR_OFFSET;
        wdata  = trans_i.input_ptr;
      end
      im2col_pkg::STEP_DST_PTR: begin
        offset = im2col_pkg::DMA_DST_PTR_OFFSET;
        wdata  = trans_i.output_ptr;
      end
      im2col_pkg::STEP_INC_SRC_D1: begin
        offset = im2col_pkg::DMA_INC_SRC_D1_OFFSET;
        wdata  = (32'(cfg_i.strides_d1) * bpe) & im2col_pkg::MASK_PAD;
      end
      im2col_pkg::STEP_INC_SRC_D2: begin
        offset = im2col_pkg::DMA_INC_SRC_D2_OFFSET;
        wdata  = (32'(trans_i.in_inc_d2) * bpe) & im2col_pkg::MASK_INC_D2;
      end
      im2col_pkg::STEP_INC_DST_D1: begin
        offset = im2col_pkg::DMA_INC_DST_D1_OFFSET;
        wdata  = bpe & im2col_pkg::MASK_PAD;  // Dense output rows
      end
      im2col_pkg::STEP_INC_DST_D2: begin
        offset = im2col_pkg::DMA_INC_DST_D2_OFFSET;
        wdata  = bpe & im2col_pkg::MASK_INC_D2;
      end
      im2col_pkg::STEP_SIZE_D2: begin
        offset = im2col_pkg::DMA_SIZE_D2_OFFSET;
        wdata  = (32'(trans_i.size_du_d2) * bpe) & im2col_pkg::MASK_SIZE;
      end
      im2col_pkg::STEP_SIZE_D1: begin
        offset = im2col_pkg::DMA_SIZE_D1_OFFSET;
        wdata  = (32'(trans_i.size_du_d1) * bpe) & im2col_pkg::MASK_SIZE;
      end
      default: begin
        offset = '0;
        wdata  = '0;
      end
    endcase
  end

  assign bus_req_o.valid = (state_q == W_REQ);
  assign bus_req_o.addr  = im2col_pkg::DMA_START_ADDRESS
                         + 32'(ch_i) * im2col_pkg::DMA_CH_SIZE + offset;
  assign bus_req_o.wdata = wdata;
  assign loaded_o        = loaded_q;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= W_IDLE;
      step_q   <= im2col_pkg::STEP_DIM;
      loaded_q <= 1'b0;
    end else begin
      loaded_q <= 1'b0;
      unique case (state_q)
        W_IDLE: begin
          if (start_i) begin
            state_q <= W_SETUP;
          end
        end
        W_SETUP: begin
          step_q  <= first_use_i ? im2col_pkg::STEP_TOP_PAD : im2col_pkg::STEP_DIM;
          state_q <= W_REQ;
        end
        W_REQ: begin
          if (bus_ready_i) begin
            if (step_q == im2col_pkg::STEP_SIZE_D1) begin
              state_q  <= W_IDLE;
              loaded_q <= 1'b1;  // Last register taken
            end else begin
              step_q  <= im2col_pkg::reg_step_e'(step_q + 4'd1);
              state_q <= W_GAP;
            end
          end
        end
        W_GAP: state_q <= W_REQ;
        default: state_q <= W_IDLE;
      endcase
    end
  end

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o.valid && !bus_ready_i |=> bus_req_o.valid && $stable(bus_req_o.addr)
      && $stable(bus_req_o.wdata));

endmodule

//--- logic/im2col_ctrl.sv
// ========================================================================
// im2col dispatch control
// Dispatch FSM, run status, end-of-run detection, done and interrupt flag
// ========================================================================

`timescale 1ns/1ps

module im2col_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic last_i,
  input  logic fifo_empty_i,
  input  logic ch_full_i,
  input  logic ch_idle_i,
  input  logic loaded_i,
  input  logic interrupt_en_i,
  input  logic ifr_read_i,
  output logic load_start_o,
  output logic pop_o,
  output logic run_end_o,
  output logic busy_o,
  output logic done_o,
  output logic irq_o
);

  typedef enum logic {
    CTRL_IDLE,
    CTRL_LOAD
  } ctrl_state_e;

  ctrl_state_e state_q;
  logic        run_q;
  logic        last_q;  // Producer has sent its final transaction
  logic        fin_q;   // Queue drained after last
  logic        done_q;
  logic        irq_q;

  assign load_start_o = (state_q == CTRL_IDLE) && run_q && !fin_q
                      && !fifo_empty_i && !ch_full_i;
  assign pop_o        = loaded_i;  // Head no longer needed
  assign run_end_o    = done_q;
  assign busy_o       = run_q;
  assign done_o       = done_q;
  assign irq_o        = irq_q;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CTRL_IDLE;
    end else if (state_q == CTRL_IDLE && load_start_o) begin
      state_q <= CTRL_LOAD;
    end else if (state_q == CTRL_LOAD && loaded_i) begin
      state_q <= CTRL_IDLE;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      run_q  <= 1'b0;
      last_q <= 1'b0;
      fin_q  <= 1'b0;
      done_q <= 1'b0;
      irq_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (done_q) begin
        run_q <= 1'b0;
      end else if (start_i) begin
        run_q <= 1'b1;
      end
      if (last_i) begin
        last_q <= 1'b1;
      end else if (last_q && run_q && fifo_empty_i && state_q == CTRL_IDLE) begin
        last_q <= 1'b0;
        fin_q  <= 1'b1;
      end
      if (fin_q && ch_idle_i) begin
        fin_q  <= 1'b0;
        done_q <= 1'b1;  // Single-cycle pulse
      end
      if (done_q && interrupt_en_i) begin
        irq_q <= 1'b1;
      end else if (ifr_read_i) begin
        irq_q <= 1'b0;
      end
    end
  end

  // Writer only finishes a sequence that this FSM started
  a_loaded_in_load: assert property (@(posedge clk_i) disable iff (!rst_ni)
    loaded_i |-> state_q == CTRL_LOAD);

endmodule

//--- logic/im2col_spc.sv
// ========================================================================
// im2col smart peripheral controller, top level
// Queue, channel allocator, register writer and dispatch control
// ========================================================================

`timescale 1ns/1ps

module im2col_spc (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  im2col_pkg::im2col_cfg_t           cfg_i,
  input  logic                              start_i,
  input  im2col_pkg::im2col_trans_t         trans_i,
  input  logic                              trans_push_i,
  input  logic                              last_i,
  input  logic                              bus_ready_i,
  input  logic [im2col_pkg::DMA_CH_NUM-1:0] dma_done_i,
  input  logic                              ifr_read_i,
  output im2col_pkg::bus_req_t              bus_req_o,
  output logic                              trans_full_o,
  output logic                              busy_o,
  output logic                              done_o,
  output logic                              irq_o
);

  im2col_pkg::im2col_trans_t       fifo_head;
  logic                            fifo_empty;
  logic                            fifo_pop;
  logic                            load_start;
  logic                            run_end;
  logic [im2col_pkg::CH_IDX_W-1:0] ch;
  logic                            first_use;
  logic                            ch_full;
  logic                            ch_idle;
  logic                            loaded;

  trans_fifo #(
    .dtype(im2col_pkg::im2col_trans_t),
    .DEPTH(im2col_pkg::FIFO_DEPTH)
  ) trans_fifo0 (
    .clk_i,
    .rst_ni,
    .push_i (trans_push_i),
    .data_i (trans_i),
    .pop_i  (fifo_pop),
    .data_o (fifo_head),
    .empty_o(fifo_empty),
    .full_o (trans_full_o)
  );

  dma_channel_alloc alloc0 (
    .clk_i,
    .rst_ni,
    .ch_mask_i  (cfg_i.ch_mask),
    .dma_done_i,
    .claim_i    (load_start),
    .run_end_i  (run_end),
    .ch_o       (ch),
    .first_use_o(first_use),
    .full_o     (ch_full),
    .idle_o     (ch_idle)
  );

  dma_reg_writer writer0 (
    .clk_i,
    .rst_ni,
    .start_i    (load_start),
    .ch_i       (ch),
    .first_use_i(first_use),
    .trans_i    (fifo_head),
    .cfg_i,
    .bus_ready_i,
    .bus_req_o,
    .loaded_o   (loaded)
  );

  im2col_ctrl ctrl0 (
    .clk_i,
    .rst_ni,
    .start_i,
    .last_i,
    .fifo_empty_i  (fifo_empty),
    .ch_full_i     (ch_full),
    .ch_idle_i     (ch_idle),
    .loaded_i      (loaded),
    .interrupt_en_i(cfg_i.interrupt_en),
    .ifr_read_i,
    .load_start_o  (load_start),
    .pop_o         (fifo_pop),
    .run_end_o     (run_end),
    .busy_o,
    .done_o,
    .irq_o
  );

endmodule

//--- testbench/tb_clock_gen.sv
// ========================================================================
// Testbench clock and reset
// 10 ns clock, active-low reset held for the first 5 cycles
// ========================================================================

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_no <= 1'b1;  // Released after the flops have sampled this edge
  end

endmodule

//--- testbench/im2col_spc_tb.sv
// ========================================================================
// im2col SPC testbench
// Runs the transactions from the input file, answers the request bus,
// models DMA completion and checks every register write and run status
// ========================================================================

`timescale 1ns/1ps

module im2col_spc_tb;

  localparam int MAX_TRANS   = 8;
  localparam int N_STEPS     = 15;
  localparam int RUN_TIMEOUT = 5000;  // Cycles per wait

  logic                              clk;
  logic                              rst_n;
  im2col_pkg::im2col_cfg_t           cfg;
  logic                              start;
  im2col_pkg::im2col_trans_t         trans;
  logic                              push;
  logic                              last;
  logic                              bus_ready;
  logic [im2col_pkg::DMA_CH_NUM-1:0] dma_done;
  logic                              ifr_read;
  im2col_pkg::bus_req_t              bus_req;
  logic                              trans_full;
  logic                              busy;
  logic                              done;
  logic                              irq;

  logic [31:0]               stim [0:255];  // Raw words of the input file
  int                        rd_pos;
  im2col_pkg::im2col_trans_t trans_tab [MAX_TRANS];
  logic [31:0]               exp_data [MAX_TRANS][N_STEPS];
  int                        run_ntrans = 0;
  int                        trans_seen = 0;  // Transactions fully written in this run
  int                        wr_idx = 0;
  int                        cur_ch = 0;
  logic                      cur_first = 1'b0;
  logic [im2col_pkg::DMA_CH_NUM-1:0] ch_used = '0;
  logic [im2col_pkg::DMA_CH_NUM-1:0] ch_busy = '0;  // From first write until done
  int                        done_wait [im2col_pkg::DMA_CH_NUM];
  int                        done_pulses = 0;
  logic [31:0]               rng = 32'd13168;
  int                        check_errs = 0;
  int                        other_errs = 0;
  logic                      aborted = 1'b0;

  tb_clock_gen clk_gen0 (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  im2col_spc dut0 (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cfg_i       (cfg),
    .start_i     (start),
    .trans_i     (trans),
    .trans_push_i(push),
    .last_i      (last),
    .bus_ready_i (bus_ready),
    .dma_done_i  (dma_done),
    .ifr_read_i  (ifr_read),
    .bus_req_o   (bus_req),
    .trans_full_o(trans_full),
    .busy_o      (busy),
    .done_o      (done),
    .irq_o       (irq)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Register offset of each write step in programming order
  function automatic logic [31:0] reg_offset(input int step);
    case (step)
      0:       return im2col_pkg::DMA_DIMENSIONALITY_OFFSET;
      1:       return im2col_pkg::DMA_SRC_DATATYPE_OFFSET;
      2:       return im2col_pkg::DMA_DST_DATATYPE_OFFSET;
      3:       return im2col_pkg::DMA_TOP_PAD_OFFSET;
      4:       return im2col_pkg::DMA_BOTTOM_PAD_OFFSET;
      5:       return im2col_pkg::DMA_LEFT_PAD_OFFSET;
      6:       return im2col_pkg::DMA_RIGHT_PAD_OFFSET;
      7:       return im2col_pkg::DMA_SRC_PTR_OFFSET;
      8:       return im2col_pkg::DMA_DST_PTR_OFFSET;
      9:       return im2col_pkg::DMA_INC_SRC_D1_OFFSET;
      10:      return im2col_pkg::DMA_INC_SRC_D2_OFFSET;
      11:      return im2col_pkg::DMA_INC_DST_D1_OFFSET;
      12:      return im2col_pkg::DMA_INC_DST_D2_OFFSET;
      13:      return im2col_pkg::DMA_SIZE_D2_OFFSET;
      14:      return im2col_pkg::DMA_SIZE_D1_OFFSET;
      default: return 32'hFFFF_FFFF;
    endcase
  endfunction

  task automatic report_error(input string what);
    other_errs++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  task automatic abort_run(input string what);
    report_error(what);
    aborted = 1'b1;
  endtask

  task automatic check_bus_req(input string name, input im2col_pkg::bus_req_t got,
                               input im2col_pkg::bus_req_t exp);
    if (got !== exp) begin
      check_errs++;
      $write("CHECK FAILED at %0t: %s got valid=%0b addr=%08h wdata=%08h", $time, name,
             got.valid, got.addr, got.wdata);
      $display(" expected valid=%0b addr=%08h wdata=%08h", exp.valid, exp.addr, exp.wdata);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      check_errs++;
      $display("CHECK FAILED at %0t: %s got %0b expected %0b", $time, name, got, exp);
    end
  endtask

  // One accepted write as seen on the falling edge before the accepting edge
  task automatic take_write();
    im2col_pkg::bus_req_t exp;
    int unsigned          ch;
    int                   step;
    if (trans_seen >= run_ntrans) begin
      report_error("bus write with no transaction left to program");
      return;
    end
    if (wr_idx == 0) begin
      ch = (bus_req.addr - im2col_pkg::DMA_START_ADDRESS) / im2col_pkg::DMA_CH_SIZE;
      if (ch >= im2col_pkg::DMA_CH_NUM) begin
        report_error("bus write outside the DMA channel range");
        return;
      end
      if (!cfg.ch_mask[ch]) begin
        report_error($sformatf("write to disabled channel %0d", ch));
      end
      if (ch_busy[ch]) begin
        report_error($sformatf("channel %0d reprogrammed before its done", ch));
      end
      cur_ch      = ch;
      cur_first   = !ch_used[ch];  // Setup writes only once per run
      ch_used[ch] = 1'b1;
      ch_busy[ch] = 1'b1;
    end
    step      = cur_first ? wr_idx : wr_idx + 3;
    exp.valid = 1'b1;
    exp.addr  = im2col_pkg::DMA_START_ADDRESS + 32'(cur_ch) * im2col_pkg::DMA_CH_SIZE
              + reg_offset(step);
    exp.wdata = exp_data[trans_seen][step];
    check_bus_req("bus_req_o", bus_req, exp);
    wr_idx++;
    if (step == N_STEPS - 1) begin
      wr_idx            = 0;
      trans_seen++;
      rng               = xorshift32(rng);
      done_wait[cur_ch] = 2 + int'(rng % 12);  // DMA finishes some cycles later
    end
  endtask

  // Bus responder, DMA model and write monitor
  always @(negedge clk) begin
    if (!rst_n) begin
      bus_ready = 1'b0;
      dma_done  = '0;
    end else begin
      dma_done = '0;
      for (int c = 0; c < im2col_pkg::DMA_CH_NUM; c++) begin
        if (done_wait[c] > 0) begin
          done_wait[c]--;
          if (done_wait[c] == 0) begin
            dma_done[c] = 1'b1;
            ch_busy[c]  = 1'b0;
          end
        end
      end
      if (done) begin
        done_pulses++;
        if (ch_busy != '0) begin
          report_error("done_o rose while a channel was still busy");
        end
        if (trans_seen != run_ntrans) begin
          report_error("done_o rose before every transaction was programmed");
        end
      end
      rng       = xorshift32(rng);
      bus_ready = (rng[1:0] != 2'b00);  // Ready about three cycles in four
      if (bus_req.valid && bus_ready) begin
        take_write();
      end
    end
  end

  task automatic run_once();
    im2col_pkg::im2col_cfg_t new_cfg;
    int                      cyc;
    new_cfg.data_type    = stim[rd_pos][1:0];
    new_cfg.strides_d1   = stim[rd_pos + 1][7:0];
    new_cfg.ch_mask      = stim[rd_pos + 2][im2col_pkg::DMA_CH_NUM-1:0];
    new_cfg.interrupt_en = stim[rd_pos + 3][0];
    run_ntrans           = stim[rd_pos + 4];
    rd_pos               = rd_pos + 5;
    if (run_ntrans > MAX_TRANS) begin
      abort_run("input file holds too many transactions for one run");
      return;
    end
    for (int t = 0; t < run_ntrans; t++) begin
      trans_tab[t].input_ptr      = stim[rd_pos];
      trans_tab[t].output_ptr     = stim[rd_pos + 1];
      trans_tab[t].n_zeros_top    = stim[rd_pos + 2][3:0];
      trans_tab[t].n_zeros_bottom = stim[rd_pos + 3][3:0];
      trans_tab[t].n_zeros_left   = stim[rd_pos + 4][3:0];
      trans_tab[t].n_zeros_right  = stim[rd_pos + 5][3:0];
      trans_tab[t].in_inc_d2      = stim[rd_pos + 6][15:0];
      trans_tab[t].size_du_d1     = stim[rd_pos + 7][15:0];
      trans_tab[t].size_du_d2     = stim[rd_pos + 8][15:0];
      for (int k = 0; k < N_STEPS; k++) begin
        exp_data[t][k] = stim[rd_pos + 9 + k];
      end
      rd_pos = rd_pos + 9 + N_STEPS;
    end
    trans_seen  = 0;
    wr_idx      = 0;
    ch_used     = '0;
    done_pulses = 0;
    cfg         = new_cfg;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    for (int t = 0; t < run_ntrans; t++) begin
      cyc = 0;
      while (trans_full && cyc < RUN_TIMEOUT) begin
        @(negedge clk);
        cyc++;
      end
      if (trans_full) begin
        abort_run("transaction queue stayed full");
        return;
      end
      trans = trans_tab[t];
      push  = 1'b1;
      @(negedge clk);
      push  = 1'b0;
    end
    // First transaction is still being written, so the queue holds every push
    check_flag("trans_full_o", trans_full, run_ntrans >= im2col_pkg::FIFO_DEPTH);
    last = 1'b1;
    @(negedge clk);
    last = 1'b0;
    cyc  = 0;
    while (!done && cyc < RUN_TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (!done) begin
      abort_run("done_o never rose after the last transaction");
      return;
    end
    @(negedge clk);
    check_flag("busy_o", busy, 1'b0);
    check_flag("irq_o", irq, cfg.interrupt_en);
    repeat (4) @(negedge clk);
    if (done_pulses != 1) begin
      report_error($sformatf("done_o pulsed %0d times in one run", done_pulses));
    end
    check_flag("irq_o", irq, cfg.interrupt_en);  // Flag holds until read
    ifr_read = 1'b1;
    @(negedge clk);
    ifr_read = 1'b0;
    check_flag("irq_o", irq, 1'b0);
  endtask

  initial begin : main
    int n_runs;
    int cyc;
    cfg       = '0;
    start     = 1'b0;
    trans     = '0;
    push      = 1'b0;
    last      = 1'b0;
    bus_ready = 1'b0;
    dma_done  = '0;
    ifr_read  = 1'b0;
    for (int c = 0; c < im2col_pkg::DMA_CH_NUM; c++) begin
      done_wait[c] = 0;
    end
    $readmemh("testbench/im2col_input.txt", stim);
    cyc = 0;
    while (!rst_n && cyc < 20) begin
      @(negedge clk);
      cyc++;
    end
    if (!rst_n) begin
      abort_run("reset was never released");
    end else begin
      check_flag("bus_req_o.valid", bus_req.valid, 1'b0);
      check_flag("busy_o", busy, 1'b0);
      check_flag("done_o", done, 1'b0);
      check_flag("irq_o", irq, 1'b0);
      if ($isunknown(stim[0])) begin
        abort_run("input file could not be read");
      end else begin
        n_runs = stim[0];
        rd_pos = 1;
        for (int r = 0; r < n_runs && !aborted; r++) begin
          run_once();
        end
      end
    end
    $display("Errors: %0d value checks, %0d other failures", check_errs, other_errs);
    if (check_errs == 0 && other_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/im2col_input.txt
// Run count, then per run: data_type strides_d1 ch_mask interrupt_en transaction_count
// Per transaction: in_ptr out_ptr top bottom left right in_inc_d2 size_d1 size_d2,
// then first-use writes (dim src_dtype dst_dtype), then the 12 data values in write order
2
0 14 5 1 4
10000000 20000000 1 2 0 3 0040 0010 0020
1 0 0
4 8 0 c 10000000 20000000 10 100 4 4 80 40
10000400 20000400 0 0 f 1 ffff 4010 0008
1 0 0
0 0 3c 4 10000400 20000400 10 3fffc 4 4 20 40
10000800 20000800 7 5 2 0 1234 0100 c000
1 0 0
1c 14 8 0 10000800 20000800 10 48d0 4 4 0 400
10000c00 20000c00 3 3 3 3 0800 0003 3fff
1 0 0
c c c c 10000c00 20000c00 10 2000 4 4 fffc c
1 3 a 0 3
30000000 40000000 f e d c 8000 0020 8001
1 1 1
1e 1c 1a 18 30000000 40000000 6 10000 2 2 2 40
30000100 40000100 1 0 2 0 0010 0007 0009
1 1 1
2 0 4 0 30000100 40000100 6 20 2 2 12 e
30000200 40000200 0 9 0 b 7fff ffff 0001
1 1 1
0 12 0 16 30000200 40000200 6 fffe 2 2 2 fffe

//--- sim.f
logic/im2col_pkg.sv
logic/trans_fifo.sv
logic/dma_channel_alloc.sv
logic/dma_reg_writer.sv
logic/im2col_ctrl.sv
logic/im2col_spc.sv
testbench/tb_clock_gen.sv
testbench/im2col_spc_tb.sv

//--- Bender.yml
package:
  name: im2col_spc

sources:
  - logic/im2col_pkg.sv
  - logic/trans_fifo.sv
  - logic/dma_channel_alloc.sv
  - logic/dma_reg_writer.sv
  - logic/im2col_ctrl.sv
  - logic/im2col_spc.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/im2col_spc_tb.sv
